// File: vlog.f
design/cache_pkg.sv
design/ahb_slave_front.sv
design/cache_line_store.sv
design/line_refill_master.sv
design/ahb_read_cache.sv
sim/ahb_mem_model.sv
sim/tb_ahb_read_cache.sv

// File: Bender.yml
package:
  name: ahb_read_cache

sources:
  - files:
      - design/cache_pkg.sv
      - design/ahb_slave_front.sv
      - design/cache_line_store.sv
      - design/line_refill_master.sv
      - design/ahb_read_cache.sv
  - target: simulation
    files:
      - sim/ahb_mem_model.sv
      - sim/tb_ahb_read_cache.sv

// File: sim/tb_ahb_read_cache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_read_cache import cache_pkg::*; ();

    localparam word_t data_pattern = 32'hc3a5_5a3c;
    localparam addr_t window_base  = 32'h0004_0000;
    localparam int    wait_limit   = 200;

    logic       upstream_intf = 1'b0;
    logic       rst_n;
    addr_t      haddr;
    htrans_t    htrans;
    logic       hwrite;
    logic [2:0] hburst;
    word_t      hwdata;
    logic       hsel;
    word_t      hrdata;
    logic       hready;
    hresp_t     hresp;
    addr_t      mem_haddr;
    htrans_t    mem_htrans;
    logic [2:0] mem_hburst;
    logic       mem_hwrite;
    word_t      mem_hrdata;
    logic       mem_hready;
    hresp_t     mem_hresp;

    int errors = 0;
    int reads  = 0;
    int misses = 0;
    int nonseq0;
    int seq0;
    int wrap0;
    int beats0;

    // reference model of the tag store
    logic [511:0] model_valid = '0;
    logic [18:0]  model_tag [512];
    logic [31:0]  lfsr_state = 32'hb5920603;

    always #5 upstream_intf = ~upstream_intf;

    ahb_read_cache u_ahb_read_cache (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .hburst        (hburst),
        .hwdata        (hwdata),
        .hsel          (hsel),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hburst    (mem_hburst),
        .mem_hwrite    (mem_hwrite),
        .mem_hrdata    (mem_hrdata),
        .mem_hready    (mem_hready),
        .mem_hresp     (mem_hresp)
    );

    ahb_mem_model #(.pattern(data_pattern)) u_ahb_mem_model (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (mem_haddr),
        .htrans        (mem_htrans),
        .hburst        (mem_hburst),
        .hwrite        (mem_hwrite),
        .hrdata        (mem_hrdata),
        .hready        (mem_hready),
        .hresp         (mem_hresp)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r          = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // index is addr[12:4], tag is addr[31:13]
    function automatic logic predict_miss(input addr_t addr);
        logic miss;
        miss = !model_valid[addr[12:4]] || model_tag[addr[12:4]] != addr[31:13];
        model_valid[addr[12:4]] = 1'b1;
        model_tag[addr[12:4]]   = addr[31:13];
        misses += miss;
        return miss;
    endfunction

    task automatic flag_error(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic timeout_abort(input string what);
        $display("timeout at %0t: hready stayed low while waiting for %s", $time, what);
        $display("Some tests failed");
        $finish;
    endtask

    task automatic wait_ready(input string what, output int stalls);
        stalls = 0;
        @(posedge upstream_intf);
        while (!hready) begin
            stalls++;
            if (stalls > wait_limit) begin
                timeout_abort(what);
            end
            @(posedge upstream_intf);
        end
    endtask

    task automatic snap_mem();
        nonseq0 = u_ahb_mem_model.nonseq_count;
        seq0    = u_ahb_mem_model.seq_count;
        wrap0   = u_ahb_mem_model.wrap4_count;
        beats0  = u_ahb_mem_model.beat_total;
    endtask

    task automatic expect_bursts(input int n);
        int d_nonseq;
        int d_seq;
        int d_wrap;
        d_nonseq = u_ahb_mem_model.nonseq_count - nonseq0;
        d_seq    = u_ahb_mem_model.seq_count - seq0;
        d_wrap   = u_ahb_mem_model.wrap4_count - wrap0;
        if (d_nonseq != n || d_wrap != n || d_seq != 3 * n) begin
            flag_error($sformatf("expected %0d bursts, memory saw %0d nonseq (%0d wrap4), %0d seq",
                                 n, d_nonseq, d_wrap, d_seq));
        end
    endtask

    // beats start at the requested word and wrap inside the line
    task automatic check_wrap(input addr_t addr, input int first);
        addr_t      exp;
        logic [1:0] off;
        for (int k = 0; k < 4; k++) begin
            off = addr[3:2] + k[1:0];
            exp = {addr[31:4], off, 2'b00};
            if (u_ahb_mem_model.beat_addr[first + k] !== exp) begin
                flag_error($sformatf("beat %0d address %h, expected %h", k,
                                     u_ahb_mem_model.beat_addr[first + k], exp));
            end
            if (u_ahb_mem_model.beat_is_seq[first + k] !== (k != 0)) begin
                flag_error($sformatf("beat %0d has the wrong htrans", k));
            end
        end
    endtask

    task automatic single_read(input addr_t addr);
        int   stalls;
        logic miss;
        miss = predict_miss(addr);
        haddr  <= addr;
        htrans <= nonseq;
        hwrite <= 1'b0;
        wait_ready("read address phase", stalls);
        htrans <= idle;
        wait_ready("read data phase", stalls);
        reads++;
        if (hrdata !== (addr ^ data_pattern)) begin
            flag_error($sformatf("read %h gave %h, expected %h", addr, hrdata,
                                 addr ^ data_pattern));
        end
        if (hresp !== okay) begin
            flag_error($sformatf("read %h got an error response", addr));
        end
        if (miss != (stalls > 0)) begin
            flag_error($sformatf("read %h took %0d wait states, miss expected %0b",
                                 addr, stalls, miss));
        end
    endtask

    task automatic reset_idle_bus();
        repeat (4) begin
            @(posedge upstream_intf);
            if (hready !== 1'b1 || hresp !== okay || mem_htrans !== idle) begin
                flag_error("bus not idle after reset");
            end
        end
    endtask

    task automatic cold_miss(input addr_t addr);
        snap_mem();
        single_read(addr);
        expect_bursts(1);
        check_wrap(addr, beats0);
    endtask

    task automatic line_hits(input addr_t addr);
        snap_mem();
        for (int k = 0; k < 4; k++) begin
            single_read({addr[31:4], k[1:0], 2'b00});
        end
        expect_bursts(0);
    endtask

    task automatic conflict_eviction(input addr_t addr);
        addr_t other;
        // next tag, same index
        other = addr ^ 32'h0000_2000;
        snap_mem();
        single_read(other);
        expect_bursts(1);
        check_wrap(other, beats0);
        snap_mem();
        single_read(addr);
        expect_bursts(1);
        check_wrap(addr, beats0);
    endtask

    task automatic write_error(input addr_t addr);
        int stalls;
        snap_mem();
        haddr  <= addr;
        htrans <= nonseq;
        hwrite <= 1'b1;
        wait_ready("write address phase", stalls);
        htrans <= idle;
        hwrite <= 1'b0;
        hwdata <= ~addr;
        @(posedge upstream_intf);
        if (hready !== 1'b0 || hresp !== error) begin
            flag_error("first cycle of write response is not a stalled error");
        end
        @(posedge upstream_intf);
        if (hready !== 1'b1 || hresp !== error) begin
            flag_error("second cycle of write response is not a ready error");
        end
        expect_bursts(0);
        single_read(addr);
    endtask

    task automatic random_pipeline();
        addr_t       addrs [40];
        logic        miss_of [40];
        logic [31:0] r;
        logic        pend;
        logic        on_bus;
        int          issued;
        int          done;
        int          stalls;
        int          n_miss;
        n_miss = 0;
        // 4 tags on 4 indices keep hits and conflicts frequent
        for (int i = 0; i < 40; i++) begin
            r          = take_bits(6);
            addrs[i]   = window_base | {17'b0, r[5:4], 7'b0, r[3:0], 2'b00};
            miss_of[i] = predict_miss(addrs[i]);
            n_miss    += miss_of[i];
        end
        snap_mem();
        issued = 0;
        done   = 0;
        stalls = 0;
        pend   = 1'b0;
        on_bus = 1'b0;
        while (done < 40) begin
            @(posedge upstream_intf);
            if (!hready) begin
                stalls++;
                if (stalls > wait_limit) begin
                    timeout_abort("pipelined read data phase");
                end
            end else begin
                if (pend) begin
                    if (hrdata !== (addrs[done] ^ data_pattern) || hresp !== okay) begin
                        flag_error($sformatf("pipelined read %h gave %h", addrs[done], hrdata));
                    end
                    if (miss_of[done] != (stalls > 0)) begin
                        flag_error($sformatf("pipelined read %h: %0d wait states, miss %0b",
                                             addrs[done], stalls, miss_of[done]));
                    end
                    done++;
                end
                stalls = 0;
                pend   = on_bus;
                on_bus = (issued < 40);
                if (on_bus) begin
                    haddr  <= addrs[issued];
                    htrans <= nonseq;
                    issued++;
                end else begin
                    htrans <= idle;
                end
            end
        end
        reads += 40;
        expect_bursts(n_miss);
    endtask

    initial begin
        rst_n  = 1'b0;
        haddr  = '0;
        htrans = idle;
        hwrite = 1'b0;
        hburst = 3'b000;
        hwdata = '0;
        hsel   = 1'b1;
        repeat (16) @(posedge upstream_intf);
        rst_n <= 1'b1;
        reset_idle_bus();
        cold_miss(32'h0000_1238);
        line_hits(32'h0000_1238);
        conflict_eviction(32'h0000_1238);
        write_error(32'h0000_1234);
        random_pipeline();
        if (u_ahb_mem_model.write_count != 0) begin
            flag_error("a write transfer reached memory");
        end
        $display("reads: %0d, misses: %0d, errors: %0d", reads, misses, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ahb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_mem_model import cache_pkg::*; #(
    parameter word_t pattern = 32'h0
) (
    input  wire logic       upstream_intf,
    input  wire logic       rst_n,
    input  addr_t           haddr,
    input  htrans_t         htrans,
    input  wire logic [2:0] hburst,
    input  wire logic       hwrite,
    output word_t           hrdata,
    output logic            hready,
    output hresp_t          hresp
);

    // beat log, read by the testbench
    int    nonseq_count;
    int    seq_count;
    int    wrap4_count;
    int    write_count;
    int    beat_total;
    addr_t beat_addr [512];
    logic  beat_is_seq [512];

    logic [31:0] lfsr_state;
    addr_t       data_addr;
    logic [1:0]  waits_left;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    assign hresp = okay;

    always @(posedge upstream_intf or negedge rst_n) begin : beat_logic
        logic [31:0] s;
        logic [1:0]  w;
        if (!rst_n) begin
            hready       <= 1'b1;
            hrdata       <= '0;
            waits_left   <= '0;
            data_addr    <= '0;
            lfsr_state   <= 32'hb5920603;
            nonseq_count <= 0;
            seq_count    <= 0;
            wrap4_count  <= 0;
            write_count  <= 0;
            beat_total   <= 0;
        end else if (!hready) begin
            if (waits_left == 2'd0) begin
                hready <= 1'b1;
                hrdata <= data_addr ^ pattern;
            end else begin
                waits_left <= waits_left - 1'b1;
            end
        end else if (htrans == nonseq || htrans == seq) begin
            // two lfsr bits give 0 to 3 wait states
            s    = lfsr_state;
            w[0] = s[0];
            s    = lfsr_next(s);
            w[1] = s[0];
            s    = lfsr_next(s);
            lfsr_state <= s;
            data_addr  <= haddr;
            if (w == 2'd0) begin
                hrdata <= haddr ^ pattern;
            end else begin
                hready     <= 1'b0;
                waits_left <= w - 1'b1;
            end
            if (htrans == nonseq) begin
                nonseq_count <= nonseq_count + 1;
            end else begin
                seq_count <= seq_count + 1;
            end
            if (htrans == nonseq && hburst == hburst_wrap4) begin
                wrap4_count <= wrap4_count + 1;
            end
            if (hwrite) begin
                write_count <= write_count + 1;
            end
            if (beat_total < 512) begin
                beat_addr[beat_total]   <= haddr;
                beat_is_seq[beat_total] <= (htrans == seq);
            end
            beat_total <= beat_total + 1;
        end
    end

endmodule

`default_nettype wire

// File: design/ahb_read_cache.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_read_cache import cache_pkg::*; (
    input  wire logic    upstream_intf,
    input  wire logic    rst_n,
    // processor side
    input  addr_t        haddr,
    input  htrans_t      htrans,
    input  wire logic    hwrite,
    input  wire logic [2:0] hburst,
    input  word_t        hwdata,
    input  wire logic    hsel,
    output word_t        hrdata,
    output logic         hready,
    output hresp_t       hresp,
    // memory side
    output addr_t        mem_haddr,
    output htrans_t      mem_htrans,
    output logic [2:0]   mem_hburst,
    output logic         mem_hwrite,
    input  word_t        mem_hrdata,
    input  wire logic    mem_hready,
    input  hresp_t       mem_hresp
);

    // hburst, hwdata and mem_hresp are not needed by a read-only cache
    addr_t lookup_addr;
    logic  hit;
    word_t hit_word;
    logic  refill_valid;
    logic  refill_ready;
    addr_t refill_addr;
    logic  fill_valid;
    addr_t fill_addr;
    line_t fill_line;

    assign mem_hwrite = 1'b0;

    ahb_slave_front u_ahb_slave_front (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .haddr         (haddr),
        .htrans        (htrans),
        .hwrite        (hwrite),
        .hsel          (hsel),
        .hrdata        (hrdata),
        .hready        (hready),
        .hresp         (hresp),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_word      (hit_word),
        .refill_valid  (refill_valid),
        .refill_addr   (refill_addr),
        .refill_ready  (refill_ready),
        .fill_valid    (fill_valid)
    );

    cache_line_store u_cache_line_store (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .lookup_addr   (lookup_addr),
        .hit           (hit),
        .hit_word      (hit_word),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr),
        .fill_line     (fill_line)
    );

    line_refill_master u_line_refill_master (
        .upstream_intf (upstream_intf),
        .rst_n         (rst_n),
        .refill_valid  (refill_valid),
        .refill_addr   (refill_addr),
        .refill_ready  (refill_ready),
        .mem_haddr     (mem_haddr),
        .mem_htrans    (mem_htrans),
        .mem_hburst    (mem_hburst),
        .mem_hrdata    (mem_hrdata),
        .mem_hready    (mem_hready),
        .fill_valid    (fill_valid),
        .fill_addr     (fill_addr),
        .fill_line     (fill_line)
    );

endmodule

`default_nettype wire

// File: design/line_refill_master.sv
`timescale 1ns/1ps
`default_nettype none

module line_refill_master import cache_pkg::*; (
    input  wire logic    upstream_intf,
    input  wire logic    rst_n,
    input  wire logic    refill_valid,
    input  addr_t        refill_addr,
    output logic         refill_ready,
    output addr_t        mem_haddr,
    output htrans_t      mem_htrans,
    output logic [2:0]   mem_hburst,
    input  word_t        mem_hrdata,
    input  wire logic    mem_hready,
    output logic         fill_valid,
    output addr_t        fill_addr,
    output line_t        fill_line
);

    refill_state_t state;
    addr_t         req_addr_q;
    offset_t       a_off;
    offset_t       d_off;
    offset_t       a_cnt;
    line_t         line_q;
    logic          take_data;

    // a data phase is open once the first address was taken
    assign take_data = mem_hready &&
                       ((state == r_addr && a_cnt != '0) || state == r_data);

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            state <= r_idle;
            a_off <= '0;
            d_off <= '0;
            a_cnt <= '0;
        end else begin
            case (state)
                r_idle: begin
                    if (refill_valid) begin
                        a_off <= refill_addr[2 +: offset_bits];
                        d_off <= refill_addr[2 +: offset_bits];
                        a_cnt <= '0;
                        state <= r_addr;
                    end
                end
                r_addr: begin
                    if (mem_hready) begin
                        // offset wraps inside the line on its own
                        a_off <= a_off + 1'b1;
                        a_cnt <= a_cnt + 1'b1;
                        if (a_cnt == offset_t'(line_words - 1)) begin
                            state <= r_data;
                        end
                    end
                end
                r_data: begin
                    if (mem_hready) begin
                        state <= r_done;
                    end
                end
                r_done: state <= r_idle;
                default: state <= r_idle;
            endcase
            if (take_data) begin
                d_off <= d_off + 1'b1;
            end
        end
    end

    always_ff @(posedge upstream_intf) begin
        if (state == r_idle && refill_valid) begin
            req_addr_q <= refill_addr;
        end
        if (take_data) begin
            line_q[32 * d_off +: 32] <= mem_hrdata;
        end
    end

    always_comb begin
        mem_htrans = idle;
        if (state == r_addr) begin
            mem_htrans = (a_cnt == '0) ? nonseq : seq;
        end
    end

    assign mem_hburst   = (state == r_addr) ? hburst_wrap4 : 3'b000;
    assign mem_haddr    = {req_addr_q[31:offset_bits + 2], a_off, 2'b00};
    assign refill_ready = (state == r_idle);
    assign fill_valid   = (state == r_done);
    assign fill_addr    = req_addr_q;
    assign fill_line    = line_q;

    // address and control held while memory inserts wait states
    a_addr_held: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        mem_htrans != idle && !mem_hready |=> $stable(mem_haddr) && $stable(mem_htrans));

    // beat k sits k words after the requested word, wrapped inside the line
    a_beat_in_line: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        mem_htrans inside {nonseq, seq} |->
            mem_haddr[31:2] == {fill_addr[31:offset_bits + 2],
                                offset_t'(fill_addr[2 +: offset_bits] + a_cnt)});

endmodule

`default_nettype wire

// File: design/cache_line_store.sv
`timescale 1ns/1ps
`default_nettype none

module cache_line_store import cache_pkg::*; (
    input  wire logic    upstream_intf,
    input  wire logic    rst_n,
    input  addr_t        lookup_addr,
    output logic         hit,
    output word_t        hit_word,
    input  wire logic    fill_valid,
    input  addr_t        fill_addr,
    input  line_t        fill_line
);

    tag_t                 tag_mem  [num_lines];
    line_t                data_mem [num_lines];
    logic [num_lines-1:0] valid_q;

    tag_t    l_tag;
    index_t  l_index;
    offset_t l_offset;
    line_t   l_line;
    tag_t    f_tag;
    index_t  f_index;

    // tag | index | word offset | byte
    assign l_tag    = lookup_addr[31 -: tag_bits];
    assign l_index  = lookup_addr[offset_bits + 2 +: index_bits];
    assign l_offset = lookup_addr[2 +: offset_bits];
    assign f_tag    = fill_addr[31 -: tag_bits];
    assign f_index  = fill_addr[offset_bits + 2 +: index_bits];

    assign l_line   = data_mem[l_index];
    assign hit      = valid_q[l_index] && (tag_mem[l_index] == l_tag);
    assign hit_word = l_line[32 * l_offset +: 32];

    always_ff @(posedge upstream_intf) begin
        if (fill_valid) begin
            tag_mem[f_index]  <= f_tag;
            data_mem[f_index] <= fill_line;
        end
    end

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[f_index] <= 1'b1;
        end
    end

    // refills only follow real misses, never a resident line
    a_no_refill_of_hit: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        fill_valid |-> !(valid_q[f_index] && tag_mem[f_index] == f_tag));

endmodule

`default_nettype wire

// File: design/ahb_slave_front.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_slave_front import cache_pkg::*; (
    input  wire logic    upstream_intf,
    input  wire logic    rst_n,
    input  addr_t        haddr,
    input  htrans_t      htrans,
    input  wire logic    hwrite,
    input  wire logic    hsel,
    output word_t        hrdata,
    output logic         hready,
    output hresp_t       hresp,
    output addr_t        lookup_addr,
    input  wire logic    hit,
    input  word_t        hit_word,
    output logic         refill_valid,
    output addr_t        refill_addr,
    input  wire logic    refill_ready,
    input  wire logic    fill_valid
);

    front_state_t state;
    addr_t        addr_q;
    logic         rd_q;
    logic         req_q;
    logic         accept;

    // a selected nonseq or seq while the bus is ready
    assign accept = hready && hsel && (htrans == nonseq || htrans == seq);

    always_comb begin
        hready = 1'b1;
        hresp  = okay;
        case (state)
            f_idle: begin
                if (rd_q && !hit) begin
                    hready = 1'b0;
                end
            end
            f_miss: hready = 1'b0;
            f_err1: begin
                hready = 1'b0;
                hresp  = error;
            end
            f_err2: hresp = error;
            default: hready = 1'b1;
        endcase
    end

    always_ff @(posedge upstream_intf) begin
        if (accept) begin
            addr_q <= haddr;
        end
    end

    always_ff @(posedge upstream_intf or negedge rst_n) begin
        if (!rst_n) begin
            state <= f_idle;
            rd_q  <= 1'b0;
            req_q <= 1'b0;
        end else begin
            case (state)
                f_idle: begin
                    if (rd_q && !hit) begin
                        state <= f_miss;
                        req_q <= 1'b1;
                    end else begin
                        rd_q <= accept && !hwrite;
                        if (accept && hwrite) begin
                            state <= f_err1;
                        end
                    end
                end
                f_miss: begin
                    if (req_q && refill_ready) begin
                        req_q <= 1'b0;
                    end
                    // word is read through the lookup once the line is in
                    if (fill_valid) begin
                        state <= f_idle;
                    end
                end
                f_err1: state <= f_err2;
                f_err2: begin
                    rd_q  <= accept && !hwrite;
                    state <= (accept && hwrite) ? f_err1 : f_idle;
                end
                default: state <= f_idle;
            endcase
        end
    end

    assign lookup_addr  = addr_q;
    assign hrdata       = hit_word;
    assign refill_valid = req_q;
    assign refill_addr  = addr_q;

    // request held with its address until taken
    a_req_stable: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        refill_valid && !refill_ready |=> refill_valid && $stable(refill_addr));

    // the refilled line hits on the first cycle back in f_idle
    a_hit_after_fill: assert property (@(posedge upstream_intf) disable iff (!rst_n)
        state == f_miss && fill_valid |=> hit && hready);

endmodule

`default_nettype wire

// File: design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // geometry
    localparam int cache_bytes = 8192;
    localparam int line_words  = 4;
    localparam int num_lines   = cache_bytes / (line_words * 4);
    localparam int index_bits  = $clog2(num_lines);
    localparam int offset_bits = $clog2(line_words);
    localparam int tag_bits    = 32 - index_bits - offset_bits - 2;

    typedef logic [31:0]                addr_t;
    typedef logic [31:0]                word_t;
    // word 0 sits in the low bits
    typedef logic [line_words*32-1:0]   line_t;
    typedef logic [tag_bits-1:0]        tag_t;
    typedef logic [index_bits-1:0]      index_t;
    typedef logic [offset_bits-1:0]     offset_t;

    // ahb encodings
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        nonseq = 2'b10,
        seq    = 2'b11
    } htrans_t;

    typedef enum logic {
        okay  = 1'b0,
        error = 1'b1
    } hresp_t;

    localparam logic [2:0] hburst_wrap4 = 3'b010;

    typedef enum logic [1:0] {f_idle, f_miss, f_err1, f_err2} front_state_t;

    typedef enum logic [1:0] {r_idle, r_addr, r_data, r_done} refill_state_t;

endpackage

`default_nettype wire
